// ==== common/periph_defines.svh ====
// Address map and width constants for the peripheral block.
// Include this header wherever an offset, a data width or the
// prescaler reset value is needed.

`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// Bus and register widths
`define DATA_W 32
`define ADDR_W 4

// Multiplier operand width, low half of a bus word
`define OPER_W 16

// Word offsets inside the block
`define ADDR_DSP_A      4'd0
`define ADDR_DSP_B      4'd1
`define ADDR_DSP_RESULT 4'd2

// Offset 3 is left unmapped
`define ADDR_PRESCALER  4'd4

// No audio enables come out until software programs a value
`define PRESCALER_RESET 32'd0

`endif

// ==== common/periph_pkg.sv ====
// Types shared across the peripheral block.
// Holds the CPU bus request and response, the decoded request
// handed to the peripherals, and the register target names.

`include "periph_defines.svh"

package periph_pkg;

    // CPU side request, fields held stable while valid is high
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] wdata;
        logic               write;
        logic               valid;
    } bus_req_t;

    // Response back to the CPU, ready is a single-cycle pulse
    typedef struct packed {
        logic [`DATA_W-1:0] rdata;
        logic               ready;
    } bus_rsp_t;

    // Register addressed by a request
    typedef enum logic [2:0] {
        tgt_none,
        tgt_dsp_a,
        tgt_dsp_b,
        tgt_dsp_result,
        tgt_prescaler
    } target_t;

    // Request after address decode, strobe marks the one active cycle
    typedef struct packed {
        target_t            target;
        logic [`DATA_W-1:0] wdata;
        logic               write;
        logic               strobe;
    } dec_req_t;

endpackage

// ==== hdl/bus_decoder.sv ====
// Front end of the peripheral bus.
// Accepts one CPU request at a time, registers it, maps the word
// offset to a register target and emits a one-cycle strobe.

`timescale 1ns/10ps

`include "periph_defines.svh"

module bus_decoder (
    input  logic                cpu_clk,
    input  logic                cpu_reset,
    input  periph_pkg::bus_req_t bus_req,
    input  logic                rsp_ready,
    output periph_pkg::dec_req_t dec_req
);
    import periph_pkg::*;

    logic               busy;
    logic               accept;
    logic               accept_q;
    logic               strobe_q;
    target_t            target_q;
    logic [`DATA_W-1:0] wdata_q;
    logic               write_q;

    function automatic target_t decode_target(input logic [`ADDR_W-1:0] addr);
        case (addr)
            `ADDR_DSP_A:      return tgt_dsp_a;
            `ADDR_DSP_B:      return tgt_dsp_b;
            `ADDR_DSP_RESULT: return tgt_dsp_result;
            `ADDR_PRESCALER:  return tgt_prescaler;
            default:          return tgt_none;
        endcase
    endfunction

    // A held valid must not be taken twice
    assign accept = bus_req.valid && !busy;

    always_ff @(posedge cpu_clk) begin
        if (cpu_reset) begin
            busy <= 1'b0;
            accept_q <= 1'b0;
            strobe_q <= 1'b0;
        end else begin
            accept_q <= accept;
            strobe_q <= accept_q;

            if (rsp_ready) begin
                busy <= 1'b0;
            end else if (accept) begin
                busy <= 1'b1;
            end
        end
    end

    // Payload stays put until the next accepted request
    always_ff @(posedge cpu_clk) begin
        if (accept) begin
            target_q <= decode_target(bus_req.addr);
            wdata_q <= bus_req.wdata;
            write_q <= bus_req.write;
        end
    end

    assign dec_req = '{target: target_q, wdata: wdata_q, write: write_q, strobe: strobe_q};

endmodule

// ==== dsp/dsp_mul.sv ====
// Memory-mapped signed 16x16 multiplier.
// Software writes operands A and B, then reads the 32-bit product,
// which is recomputed every cycle from the operand registers.

`timescale 1ns/10ps

`include "periph_defines.svh"

module dsp_mul (
    input  logic                 cpu_clk,
    input  periph_pkg::dec_req_t dec_req,
    output logic [`DATA_W-1:0]   product
);
    import periph_pkg::*;

    // Operands A and B, zero at power-up
    logic signed [`OPER_W-1:0] oper_a = '0;
    logic signed [`OPER_W-1:0] oper_b = '0;
    logic                      wr_a;
    logic                      wr_b;

    assign wr_a = dec_req.strobe && dec_req.write && (dec_req.target == tgt_dsp_a);
    assign wr_b = dec_req.strobe && dec_req.write && (dec_req.target == tgt_dsp_b);

    // Operand capture and product register
    always_ff @(posedge cpu_clk) begin
        if (wr_a) begin
            oper_a <= dec_req.wdata[`OPER_W-1:0];
        end

        if (wr_b) begin
            oper_b <= dec_req.wdata[`OPER_W-1:0];
        end

        // Both operands signed, so they extend to the full product width
        product <= oper_a * oper_b;
    end

endmodule

// ==== audio/audio_clock_gen.sv ====
// Audio clock enable generator for the synth core.
// Software programs a 32-bit phase increment; every carry out of the
// accumulator gives one synth enable, every second one a half-rate enable.

`timescale 1ns/10ps

`include "periph_defines.svh"

module audio_clock_gen (
    input  logic                 cpu_clk,
    input  logic                 cpu_reset,
    input  periph_pkg::dec_req_t dec_req,
    output logic [`DATA_W-1:0]   prescaler,
    output logic                 audio_cen,
    output logic                 audio_cen_p1
);
    import periph_pkg::*;

    logic [`DATA_W:0] phase_acc;
    logic             tick;
    logic             cen_p1_toggle;
    logic             prescaler_wr;

    assign prescaler_wr = dec_req.strobe && dec_req.write && (dec_req.target == tgt_prescaler);

    // Software phase increment
    always_ff @(posedge cpu_clk) begin
        if (cpu_reset) begin
            prescaler <= `PRESCALER_RESET;
        end else if (prescaler_wr) begin
            prescaler <= dec_req.wdata;
        end
    end

    // Fractional accumulator, the top bit is the carry
    always_ff @(posedge cpu_clk) begin
        if (cpu_reset) begin
            phase_acc <= '0;
            tick <= 1'b0;
        end else begin
            tick <= 1'b0;
            phase_acc <= phase_acc + {1'b0, prescaler};

            // Carry seen, consume it and flag a tick
            if (phase_acc[`DATA_W]) begin
                tick <= 1'b1;
                phase_acc[`DATA_W] <= 1'b0;
            end
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (cpu_reset) begin
            audio_cen <= 1'b0;
            audio_cen_p1 <= 1'b0;
            cen_p1_toggle <= 1'b0;
        end else begin
            audio_cen <= 1'b0;
            audio_cen_p1 <= 1'b0;

            if (tick) begin
                audio_cen <= 1'b1;

                // Half rate, first fires on the second tick
                audio_cen_p1 <= cen_p1_toggle;
                cen_p1_toggle <= !cen_p1_toggle;
            end
        end
    end

endmodule

// ==== hdl/bus_responder.sv ====
// Back end of the peripheral bus.
// Picks the read data of the addressed peripheral on a strobe and
// returns it to the CPU with a single-cycle ready.

`timescale 1ns/10ps

`include "periph_defines.svh"

module bus_responder (
    input  logic                 cpu_clk,
    input  logic                 cpu_reset,
    input  periph_pkg::dec_req_t dec_req,
    input  logic [`DATA_W-1:0]   product,
    input  logic [`DATA_W-1:0]   prescaler,
    output periph_pkg::bus_rsp_t bus_rsp
);
    import periph_pkg::*;

    logic [`DATA_W-1:0] read_sel;
    logic [`DATA_W-1:0] rdata_q;
    logic               ready_q;

    // Operand registers are write-only, unmapped reads give zero
    always_comb begin
        case (dec_req.target)
            tgt_dsp_result: read_sel = product;
            tgt_prescaler:  read_sel = prescaler;
            default:        read_sel = '0;
        endcase
    end

    always_ff @(posedge cpu_clk) begin
        if (cpu_reset) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= dec_req.strobe;
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (dec_req.strobe) begin
            rdata_q <= read_sel;
        end
    end

    assign bus_rsp = '{rdata: rdata_q, ready: ready_q};

endmodule

// ==== hdl/periph_top.sv ====
// Peripheral block top level.
// Connects the bus decoder, the multiplier, the audio clock
// generator and the bus responder. One clock, one request in flight.

`timescale 1ns/10ps

`include "periph_defines.svh"

module periph_top (
    input  logic                 cpu_clk,
    input  logic                 cpu_reset,
    input  periph_pkg::bus_req_t bus_req,
    output periph_pkg::bus_rsp_t bus_rsp,
    output logic                 audio_cen,
    output logic                 audio_cen_p1
);
    import periph_pkg::*;

    dec_req_t           dec_req;
    logic [`DATA_W-1:0] product;
    logic [`DATA_W-1:0] prescaler;

    // Request path
    bus_decoder bus_decoder_inst (
        .cpu_clk(cpu_clk),
        .cpu_reset(cpu_reset),
        .bus_req(bus_req),
        .rsp_ready(bus_rsp.ready),
        .dec_req(dec_req)
    );

    // Peripherals

    dsp_mul dsp_mul_inst (
        .cpu_clk(cpu_clk),
        .dec_req(dec_req),
        .product(product)
    );

    audio_clock_gen audio_clock_gen_inst (
        .cpu_clk(cpu_clk),
        .cpu_reset(cpu_reset),
        .dec_req(dec_req),
        .prescaler(prescaler),
        .audio_cen(audio_cen),
        .audio_cen_p1(audio_cen_p1)
    );

    // Response path, ready also frees the decoder
    bus_responder bus_responder_inst (
        .cpu_clk(cpu_clk),
        .cpu_reset(cpu_reset),
        .dec_req(dec_req),
        .product(product),
        .prescaler(prescaler),
        .bus_rsp(bus_rsp)
    );

endmodule

// ==== sim/periph_props.sv ====
// Handshake and clock enable properties for the peripheral block.
// Bound into the top level; a failing property raises its flag.

`timescale 1ns/10ps

module periph_props (
    input logic cpu_clk,
    input logic cpu_reset,
    input logic ready,
    input logic strobe,
    input logic audio_cen,
    input logic audio_cen_p1
);

    logic prop_fail = 1'b0;

    // Ready is a single-cycle pulse
    ready_single: assert property (@(posedge cpu_clk) disable iff (cpu_reset)
        ready |=> !ready)
        else begin
            prop_fail = 1'b1;
            $error("ready stayed high for two cycles");
        end

    ready_after_strobe: assert property (@(posedge cpu_clk) disable iff (cpu_reset)
        $rose(ready) |-> $past(strobe))
        else begin
            prop_fail = 1'b1;
            $error("ready rose without a strobe the cycle before");
        end

    // Half-rate enable is a subset of the synth enable
    cen_p1_with_cen: assert property (@(posedge cpu_clk) disable iff (cpu_reset)
        audio_cen_p1 |-> audio_cen)
        else begin
            prop_fail = 1'b1;
            $error("audio_cen_p1 high without audio_cen");
        end

endmodule

bind periph_top periph_props periph_props_inst (
    .cpu_clk(cpu_clk),
    .cpu_reset(cpu_reset),
    .ready(bus_rsp.ready),
    .strobe(dec_req.strobe),
    .audio_cen(audio_cen),
    .audio_cen_p1(audio_cen_p1)
);

// ==== sim/periph_tb.sv ====
// Testbench for the peripheral block, acting as the CPU.
// Applies a table of bus reads and writes, checks read data and handshake
// timing, then measures the audio clock enable rates over a fixed window.

`timescale 1ns/10ps

`include "periph_defines.svh"

module periph_tb;
    import periph_pkg::*;

    // One bus operation with the read data it should return
    typedef struct packed {
        logic               is_write;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] wdata;
        logic [`DATA_W-1:0] expected;
    } table_entry_t;

    logic     cpu_clk;
    logic     cpu_reset;
    bus_req_t bus_req;
    bus_rsp_t bus_rsp;
    logic     audio_cen;
    logic     audio_cen_p1;

    table_entry_t op_table[$];
    int           cycle_count = 0;
    int           cycle_limit = 0;

    periph_top periph_top_inst (
        .cpu_clk(cpu_clk),
        .cpu_reset(cpu_reset),
        .bus_req(bus_req),
        .bus_rsp(bus_rsp),
        .audio_cen(audio_cen),
        .audio_cen_p1(audio_cen_p1)
    );

    initial begin
        cpu_clk = 1'b0;
        forever #5 cpu_clk = ~cpu_clk;
    end

    always @(posedge cpu_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: run still going after %0d cycles", cycle_limit);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("sim failed");
            $fatal(1, "check failed");
        end
    endtask

    // Nominal value unless the measured one is within one of it
    function automatic logic [31:0] expect_within_one(input logic [31:0] actual,
                                                      input logic [31:0] nominal);
        if ((actual + 32'd1 >= nominal) && (actual <= nominal + 32'd1)) begin
            return actual;
        end
        return nominal;
    endfunction

    // Valid is sampled at the first edge, ready follows two edges later
    task automatic run_access(input logic is_write, input logic [`ADDR_W-1:0] addr,
                              input logic [`DATA_W-1:0] wdata,
                              output logic [`DATA_W-1:0] rdata);
        int edges;
        edges = 0;
        bus_req = '{addr: addr, wdata: wdata, write: is_write, valid: 1'b1};
        do begin
            @(negedge cpu_clk);
            edges++;
        end while (!bus_rsp.ready);
        rdata = bus_rsp.rdata;
        bus_req.valid = 1'b0;
        check_value("bus_rsp.ready latency", 32'(edges), 32'd3);
        @(negedge cpu_clk);
        check_value("bus_rsp.ready after pulse", 32'(bus_rsp.ready), 32'd0);
    endtask

    task automatic bus_write(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
        logic [`DATA_W-1:0] unused_rdata;
        run_access(1'b1, addr, data, unused_rdata);
    endtask

    task automatic bus_read(input logic [`ADDR_W-1:0] addr, output logic [`DATA_W-1:0] data);
        run_access(1'b0, addr, '0, data);
    endtask

    task automatic add_entry(input logic is_write, input logic [`ADDR_W-1:0] addr,
                             input logic [`DATA_W-1:0] wdata, input logic [`DATA_W-1:0] expected);
        table_entry_t entry;
        entry.is_write = is_write;
        entry.addr = addr;
        entry.wdata = wdata;
        entry.expected = expected;
        op_table.push_back(entry);
    endtask

    task automatic build_table();
        logic [31:0]        a_word;
        logic [31:0]        b_word;
        logic [31:0]        p_word;
        logic signed [15:0] a_op;
        logic signed [15:0] b_op;
        logic signed [31:0] prod;
        // Reset state of the prescaler and the product
        add_entry(1'b0, `ADDR_PRESCALER, '0, 32'd0);
        add_entry(1'b0, `ADDR_DSP_RESULT, '0, 32'd0);
        for (int r = 0; r < 4; r++) begin
            a_word = (r == 0) ? 32'h1234_8000 : $urandom;
            b_word = (r == 0) ? 32'habcd_8000 : $urandom;
            a_op = a_word[15:0];
            b_op = b_word[15:0];
            prod = a_op * b_op;
            add_entry(1'b1, `ADDR_DSP_A, a_word, '0);
            add_entry(1'b1, `ADDR_DSP_B, b_word, '0);
            add_entry(1'b0, `ADDR_DSP_RESULT, '0, prod);
            // Result offset is read only
            add_entry(1'b1, `ADDR_DSP_RESULT, $urandom, '0);
            add_entry(1'b0, `ADDR_DSP_RESULT, '0, prod);
        end
        p_word = $urandom;
        add_entry(1'b1, `ADDR_PRESCALER, p_word, '0);
        add_entry(1'b0, `ADDR_PRESCALER, '0, p_word);
        add_entry(1'b0, 4'd3, '0, 32'd0);
        add_entry(1'b0, 4'd5, '0, 32'd0);
        add_entry(1'b0, 4'd15, '0, 32'd0);
        add_entry(1'b1, 4'd6, $urandom, '0);
        add_entry(1'b0, `ADDR_PRESCALER, '0, p_word);
    endtask

    initial begin
        logic [`DATA_W-1:0] rdata;
        logic [`DATA_W-1:0] meas_p;
        logic [63:0]        scaled;
        int                 cen_count;
        int                 p1_count;

        void'($urandom(60617));
        cpu_reset = 1'b1;
        bus_req = '0;
        build_table();
        cycle_limit = 4 * op_table.size() * 4 + 2000;

        repeat (5) @(negedge cpu_clk);
        cpu_reset = 1'b0;
        @(negedge cpu_clk);
        check_value("bus_rsp.ready", 32'(bus_rsp.ready), 32'd0);
        check_value("audio_cen", 32'(audio_cen), 32'd0);
        check_value("audio_cen_p1", 32'(audio_cen_p1), 32'd0);

        foreach (op_table[i]) begin
            if (op_table[i].is_write) begin
                bus_write(op_table[i].addr, op_table[i].wdata);
            end else begin
                bus_read(op_table[i].addr, rdata);
                check_value($sformatf("bus_rsp.rdata at offset %0h", op_table[i].addr),
                            rdata, op_table[i].expected);
            end
        end

        // Keep the rate below half so no carry is ever merged
        meas_p = ($urandom % 32'h0400_0000) + 32'h0400_0000;
        bus_write(`ADDR_PRESCALER, meas_p);
        repeat (4) @(negedge cpu_clk);
        cen_count = 0;
        p1_count = 0;
        repeat (2000) begin
            @(negedge cpu_clk);
            if (audio_cen) begin
                cen_count++;
            end
            if (audio_cen_p1) begin
                p1_count++;
            end
        end
        scaled = 64'd2000 * 64'(meas_p);
        check_value("audio_cen count", 32'(cen_count),
                    expect_within_one(32'(cen_count), scaled[63:32]));
        check_value("audio_cen_p1 count", 32'(p1_count),
                    expect_within_one(32'(p1_count), 32'(cen_count / 2)));

        if (periph_top_inst.periph_props_inst.prop_fail) begin
            $display("An assertion on the bus handshake or audio enables failed");
            $display("sim failed");
            $fatal(1, "assertion failure");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// ==== src.f ====
+incdir+common
common/periph_pkg.sv
hdl/bus_decoder.sv
dsp/dsp_mul.sv
audio/audio_clock_gen.sv
hdl/bus_responder.sv
hdl/periph_top.sv
sim/periph_props.sv
sim/periph_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the peripheral block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module periph_tb

# The log decides the result, a failing run may also exit nonzero
./obj_dir/Vperiph_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "^sim passed$" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
